// File: sq_config_pkg.sv
package sq_config_pkg;

	//////////////////////////////////////////////////
	// queue geometry
	//////////////////////////////////////////////////

	// number of store entries
	localparam int sq_depth = 8;
	localparam int sq_index_bits = 3;

	//////////////////////////////////////////////////
	// datapath widths
	//////////////////////////////////////////////////

	localparam int addr_bits = 32;
	localparam int data_bits = 32;
	// physical register tag
	localparam int tag_bits = 6;
	localparam int rob_bits = 5;

endpackage

// File: sq_types_pkg.sv
package sq_types_pkg;

	import sq_config_pkg::*;

	//////////////////////////////////////////////////
	// queue positions
	//////////////////////////////////////////////////

	typedef logic [sq_index_bits-1:0] sq_index_t;
	// one bit wider so a full queue is distinct from empty
	typedef logic [sq_index_bits:0] sq_count_t;

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////

	// effective address and also the offset
	typedef logic [addr_bits-1:0] addr_t;
	typedef logic [data_bits-1:0] data_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [rob_bits-1:0] rob_index_t;

	// head store request to the data cache
	typedef enum logic {idle, issue} commit_state_t;

endpackage

// File: sq_alloc.sv
`timescale 1ns/1ns

module sq_alloc
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      mispredict,
	input  logic      disp_valid,
	input  logic      retire_en,
	output logic      disp_ready,
	output logic      alloc_en,
	output sq_index_t alloc_index
);

	sq_index_t tail;
	sq_count_t count;

	// occupancy alone decides whether a slot is free
	assign disp_ready = count < sq_count_t'(sq_depth);
	assign alloc_en = disp_valid && disp_ready;
	assign alloc_index = tail;

	//////////////////////////////////////////////////
	// tail pointer
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tail <= '0;
		end else if (alloc_en) begin
			// wraps at the queue depth
			tail <= tail + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			count <= '0;
		end else begin
			case ({alloc_en, retire_en})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				// both or neither leave the count alone
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

// File: sq_entry_array.sv
`timescale 1ns/1ns

module sq_entry_array
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                mispredict,
	input  logic                alloc_en,
	input  logic                agu_en,
	input  logic                retire_en,
	input  logic                cdb_valid,
	input  sq_index_t           alloc_index,
	input  sq_index_t           agu_index,
	input  sq_index_t           head_index,
	input  tag_t                disp_data_tag,
	input  tag_t                disp_base_tag,
	input  data_t               disp_data,
	input  data_t               disp_base,
	input  addr_t               disp_offset,
	input  rob_index_t          disp_rob_index,
	input  logic                disp_data_ready,
	input  logic                disp_base_ready,
	input  tag_t                cdb_tag,
	input  data_t               cdb_value,
	input  addr_t               agu_addr,
	output logic [sq_depth-1:0] addr_pending,
	output data_t               base_array [sq_depth],
	output addr_t               offset_array [sq_depth],
	output logic                head_valid,
	output logic                head_resolved,
	output logic                head_data_ready,
	output rob_index_t          head_rob_index,
	output addr_t               head_addr,
	output data_t               head_data
);

	// per-entry status
	logic [sq_depth-1:0] valid;
	logic [sq_depth-1:0] resolved;
	logic [sq_depth-1:0] base_ready;
	logic [sq_depth-1:0] data_ready;

	// per-entry payload
	data_t      base_value [sq_depth];
	data_t      data_value [sq_depth];
	tag_t       base_tag [sq_depth];
	tag_t       data_tag [sq_depth];
	addr_t      offset [sq_depth];
	addr_t      addr [sq_depth];
	rob_index_t rob_index [sq_depth];

	logic [sq_depth-1:0] base_wake;
	logic [sq_depth-1:0] data_wake;
	logic disp_base_hit;
	logic disp_data_hit;

	//////////////////////////////////////////////////
	// result bus tag match
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < sq_depth; i++) begin
			base_wake[i] = cdb_valid && valid[i] && !base_ready[i] && base_tag[i] == cdb_tag;
			data_wake[i] = cdb_valid && valid[i] && !data_ready[i] && data_tag[i] == cdb_tag;
		end
	end

	// a store written this cycle can catch the broadcast too
	assign disp_base_hit = cdb_valid && !disp_base_ready && disp_base_tag == cdb_tag;
	assign disp_data_hit = cdb_valid && !disp_data_ready && disp_data_tag == cdb_tag;

	//////////////////////////////////////////////////
	// status flags
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			valid <= '0;
			resolved <= '0;
			base_ready <= '0;
			data_ready <= '0;
		end else begin
			for (int i = 0; i < sq_depth; i++) begin
				if (alloc_en && alloc_index == sq_index_t'(i)) begin
					valid[i] <= 1'b1;
					resolved[i] <= 1'b0;
					base_ready[i] <= disp_base_ready || disp_base_hit;
					data_ready[i] <= disp_data_ready || disp_data_hit;
				end else if (retire_en && head_index == sq_index_t'(i)) begin
					valid[i] <= 1'b0;
					resolved[i] <= 1'b0;
					base_ready[i] <= 1'b0;
					data_ready[i] <= 1'b0;
				end else begin
					if (agu_en && agu_index == sq_index_t'(i) && valid[i]) begin
						resolved[i] <= 1'b1;
					end
					if (base_wake[i]) begin
						base_ready[i] <= 1'b1;
					end
					if (data_wake[i]) begin
						data_ready[i] <= 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// payload storage
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < sq_depth; i++) begin
			if (alloc_en && alloc_index == sq_index_t'(i)) begin
				base_value[i] <= disp_base_hit ? cdb_value : disp_base;
				data_value[i] <= disp_data_hit ? cdb_value : disp_data;
				base_tag[i] <= disp_base_tag;
				data_tag[i] <= disp_data_tag;
				offset[i] <= disp_offset;
				rob_index[i] <= disp_rob_index;
			end else begin
				if (base_wake[i]) begin
					base_value[i] <= cdb_value;
				end
				if (data_wake[i]) begin
					data_value[i] <= cdb_value;
				end
				if (agu_en && agu_index == sq_index_t'(i)) begin
					addr[i] <= agu_addr;
				end
			end
		end
	end

	// entries waiting for address generation
	assign addr_pending = valid & base_ready & ~resolved;
	assign base_array = base_value;
	assign offset_array = offset;

	assign head_valid = valid[head_index];
	assign head_resolved = resolved[head_index];
	assign head_data_ready = data_ready[head_index];
	assign head_rob_index = rob_index[head_index];
	assign head_addr = addr[head_index];
	assign head_data = data_value[head_index];

endmodule

// File: sq_agu.sv
`timescale 1ns/1ns

module sq_agu
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                mispredict,
	input  logic [sq_depth-1:0] addr_pending,
	input  data_t               base_array [sq_depth],
	input  addr_t               offset_array [sq_depth],
	output logic                agu_en,
	output sq_index_t           agu_index,
	output addr_t               agu_addr
);

	logic [sq_depth-1:0] candidates;
	logic [sq_depth-1:0] grant;
	sq_index_t pick_index;
	logic pick_valid;

	//////////////////////////////////////////////////
	// select the lowest pending entry
	//////////////////////////////////////////////////

	always_comb begin
		candidates = addr_pending;
		// entry in the output register still shows pending this cycle
		if (agu_en) begin
			candidates[agu_index] = 1'b0;
		end
	end

	// isolate the lowest set bit
	assign grant = candidates & (~candidates + 1'b1);
	assign pick_valid = |candidates;

	always_comb begin
		pick_index = '0;
		for (int i = 0; i < sq_depth; i++) begin
			if (grant[i]) begin
				pick_index = sq_index_t'(i);
			end
		end
	end

	//////////////////////////////////////////////////
	// address stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			agu_en <= 1'b0;
		end else begin
			agu_en <= pick_valid;
		end
	end

	always_ff @(posedge clock) begin
		agu_index <= pick_index;
		// wraps modulo 2^32
		agu_addr <= addr_t'(base_array[pick_index]) + offset_array[pick_index];
	end

endmodule

// File: sq_commit.sv
`timescale 1ns/1ns

module sq_commit
	import sq_types_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       mispredict,
	input  logic       store_ready,
	input  logic       head_valid,
	input  logic       head_resolved,
	input  logic       head_data_ready,
	input  rob_index_t rob_head_index,
	input  rob_index_t head_rob_index,
	input  addr_t      head_addr,
	input  data_t      head_data,
	output sq_index_t  head_index,
	output logic       retire_en,
	output logic       store_valid,
	output addr_t      store_addr,
	output data_t      store_data,
	output rob_index_t store_rob_index
);

	commit_state_t state;
	logic head_eligible;

	// head must be the oldest instruction in the ROB and fully formed
	assign head_eligible = head_valid && head_resolved && head_data_ready
		&& head_rob_index == rob_head_index;

	assign store_valid = state == issue;
	// one cycle pulse on the cache handshake
	assign retire_en = store_valid && store_ready;

	//////////////////////////////////////////////////
	// commit FSM and head pointer
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			state <= idle;
			head_index <= '0;
		end else begin
			case (state)
				idle: begin
					if (head_eligible) begin
						state <= issue;
					end
				end
				issue: begin
					if (store_ready) begin
						state <= idle;
						head_index <= head_index + 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// request payload held steady while waiting on the cache
	always_ff @(posedge clock) begin
		if (state == idle && head_eligible) begin
			store_addr <= head_addr;
			store_data <= head_data;
			store_rob_index <= head_rob_index;
		end
	end

endmodule

// File: store_queue.sv
`timescale 1ns/1ns

module store_queue
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       mispredict,
	input  logic       disp_valid,
	output logic       disp_ready,
	input  tag_t       disp_data_tag,
	input  data_t      disp_data,
	input  logic       disp_data_ready,
	input  tag_t       disp_base_tag,
	input  data_t      disp_base,
	input  logic       disp_base_ready,
	input  addr_t      disp_offset,
	input  rob_index_t disp_rob_index,
	input  logic       cdb_valid,
	input  tag_t       cdb_tag,
	input  data_t      cdb_value,
	input  rob_index_t rob_head_index,
	input  logic       store_ready,
	output logic       store_valid,
	output addr_t      store_addr,
	output data_t      store_data,
	output rob_index_t store_rob_index
);

	// allocate to array
	logic alloc_en;
	sq_index_t alloc_index;

	// array to address stage and back
	logic [sq_depth-1:0] addr_pending;
	data_t base_array [sq_depth];
	addr_t offset_array [sq_depth];
	logic agu_en;
	sq_index_t agu_index;
	addr_t agu_addr;

	// head entry and retire
	sq_index_t head_index;
	logic head_valid;
	logic head_resolved;
	logic head_data_ready;
	rob_index_t head_rob_index;
	addr_t head_addr;
	data_t head_data;
	logic retire_en;

	sq_alloc u_alloc (.*);
	sq_entry_array u_entry_array (.*);
	sq_agu u_agu (.*);
	sq_commit u_commit (.*);

endmodule

// File: sq_assert.sv
`timescale 1ns/1ns

module sq_assert
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input logic       clock,
	input logic       reset,
	input logic       mispredict,
	input logic       disp_valid,
	input logic       disp_ready,
	input logic       store_valid,
	input logic       store_ready,
	input addr_t      store_addr,
	input data_t      store_data,
	input rob_index_t store_rob_index
);

	sq_count_t outstanding;
	int failures = 0;

	// stores accepted at dispatch and not yet taken by the cache
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + sq_count_t'(disp_valid && disp_ready)
				- sq_count_t'(store_valid && store_ready);
		end
	end

	payload_held: assert property (@(posedge clock) disable iff (reset)
		store_valid && !store_ready && !mispredict |=> store_valid && $stable(store_addr)
			&& $stable(store_data) && $stable(store_rob_index))
		else begin
			$error("store payload changed while the cache held off");
			failures++;
		end

	full_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
		outstanding == sq_count_t'(sq_depth) |-> !disp_ready)
		else begin
			$error("disp_ready high with the queue full");
			failures++;
		end

	idle_after_reset: assert property (@(posedge clock) reset |=> !store_valid)
		else begin
			$error("store_valid high right after reset");
			failures++;
		end

endmodule

bind store_queue sq_assert u_sq_assert (.*);

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// reset drops on a falling edge after 10 cycles
	initial begin
		reset = 1'b1;
		repeat (10) @(negedge clock);
		reset = 1'b0;
	end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker
	import sq_config_pkg::*;
	import sq_types_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       mispredict,
	input  logic       disp_valid,
	input  logic       disp_ready,
	input  logic       store_valid,
	input  logic       store_ready,
	input  addr_t      store_addr,
	input  data_t      store_data,
	input  rob_index_t store_rob_index,
	input  addr_t      exp_addr,
	input  data_t      exp_data,
	input  rob_index_t exp_rob,
	input  int         test_id,
	output int         check_count,
	output int         error_count,
	output int         pending
);

	// expected stores in program order
	addr_t addr_q [$];
	data_t data_q [$];
	rob_index_t rob_q [$];

	initial begin
		check_count = 0;
		error_count = 0;
		pending = 0;
	end

	function automatic string test_label(int id);
		case (id)
			0: return "in_order";
			1: return "wakeup";
			2: return "backpressure";
			3: return "full_queue";
			default: return "mispredict";
		endcase
	endfunction

	task automatic compare(string field, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s %s: expected %h, actual %h",
				test_label(test_id), field, expected, actual);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// cache port and dispatch handshakes
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset || mispredict) begin
			// a flush drops every store still queued
			addr_q.delete();
			data_q.delete();
			rob_q.delete();
		end else begin
			if (store_valid && store_ready) begin
				check_count++;
				if (addr_q.size() == 0) begin
					$display("%s: a store to %h reached the cache with none outstanding",
						test_label(test_id), store_addr);
					error_count++;
				end else begin
					compare("address", addr_q.pop_front(), store_addr);
					compare("data", data_q.pop_front(), store_data);
					compare("rob index", rob_q.pop_front(), store_rob_index);
				end
			end
			if (disp_valid && disp_ready) begin
				addr_q.push_back(exp_addr);
				data_q.push_back(exp_data);
				rob_q.push_back(exp_rob);
			end
		end
		pending = addr_q.size();
	end

endmodule

// File: tb_store_queue.sv
`timescale 1ns/1ns

module tb_store_queue
	import sq_config_pkg::*;
	import sq_types_pkg::*;
();

	localparam int n_in_order = 16;
	localparam int n_wakeup = 12;
	localparam int n_backpressure = 24;
	localparam int n_full = sq_depth + 1;
	localparam int n_flush = 12;
	localparam int cycle_limit =
		(n_in_order + n_wakeup + n_backpressure + n_full + n_flush) * 20 + 200;

	// store_ready modes
	localparam int ready_high = 0;
	localparam int ready_random = 1;
	localparam int ready_low = 2;

	logic clock;
	logic reset;
	logic mispredict;
	logic disp_valid;
	logic disp_ready;
	tag_t disp_data_tag;
	data_t disp_data;
	logic disp_data_ready;
	tag_t disp_base_tag;
	data_t disp_base;
	logic disp_base_ready;
	addr_t disp_offset;
	rob_index_t disp_rob_index;
	logic cdb_valid;
	tag_t cdb_tag;
	data_t cdb_value;
	rob_index_t rob_head_index;
	logic store_ready;
	logic store_valid;
	addr_t store_addr;
	data_t store_data;
	rob_index_t store_rob_index;

	// reference model state
	addr_t exp_addr;
	data_t exp_data;
	rob_index_t exp_rob;
	rob_index_t next_rob;
	rob_index_t head_rob;
	tag_t next_tag;
	int test_id;
	int ready_mode;
	int other_errors;
	int cycle_count = 0;
	int check_count;
	int error_count;
	int pending;
	integer seed;

	tb_clock_gen u_clock_gen (.*);
	store_queue dut (.*);
	tb_checker u_checker (.*);

	// expected effective address wraps modulo 2^32
	function automatic addr_t store_address(data_t base, addr_t offset);
		return base + offset;
	endfunction

	// oldest store not yet taken by the cache
	always @(posedge clock) begin
		if (reset) begin
			head_rob <= '0;
		end else if (mispredict) begin
			head_rob <= next_rob;
		end else if (store_valid && store_ready) begin
			head_rob <= head_rob + 1'b1;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	task automatic next_cycle();
		integer coin;
		@(negedge clock);
		coin = $random(seed);
		cdb_valid = 1'b0;
		rob_head_index = head_rob;
		if (ready_mode == ready_high) begin
			store_ready = 1'b1;
		end else if (ready_mode == ready_random) begin
			store_ready = coin[0];
		end else begin
			store_ready = 1'b0;
		end
	endtask

	// holds the request until the queue takes it
	task automatic dispatch_store(input data_t base, input logic base_known, input addr_t offset,
			input data_t data, input logic data_known, input tag_t base_tag, input tag_t data_tag);
		disp_valid = 1'b1;
		disp_base_ready = base_known;
		disp_base = base_known ? base : ~base;
		disp_base_tag = base_tag;
		disp_data_ready = data_known;
		disp_data = data_known ? data : ~data;
		disp_data_tag = data_tag;
		disp_offset = offset;
		disp_rob_index = next_rob;
		exp_addr = store_address(base, offset);
		exp_data = data;
		exp_rob = next_rob;
		while (!disp_ready) begin
			next_cycle();
		end
		next_cycle();
		disp_valid = 1'b0;
		next_rob = next_rob + 1'b1;
	endtask

	task automatic send_ready_stores(int count);
		data_t base;
		addr_t offset;
		data_t data;
		for (int i = 0; i < count; i++) begin
			base = $random(seed);
			offset = $random(seed);
			data = $random(seed);
			dispatch_store(base, 1'b1, offset, data, 1'b1, '0, '0);
		end
	endtask

	task automatic broadcast(input tag_t tag, input data_t value);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_value = value;
		next_cycle();
	endtask

	task automatic drain();
		while (pending != 0) begin
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		data_t base;
		addr_t offset;
		data_t data;
		tag_t tag_b;
		tag_t tag_d;
		int total;
		seed = 32'hd565_e4ad;
		mispredict = 1'b0;
		disp_valid = 1'b0;
		disp_data_tag = '0;
		disp_data = '0;
		disp_data_ready = 1'b0;
		disp_base_tag = '0;
		disp_base = '0;
		disp_base_ready = 1'b0;
		disp_offset = '0;
		disp_rob_index = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		rob_head_index = '0;
		store_ready = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		exp_rob = '0;
		next_rob = '0;
		next_tag = '0;
		test_id = 0;
		ready_mode = ready_high;
		other_errors = 0;
		@(negedge reset);
		next_cycle();

		// the first address wraps past 2^32
		dispatch_store(32'hffff_fff0, 1'b1, 32'h40, 32'h1234_5678, 1'b1, '0, '0);
		send_ready_stores(n_in_order - 1);
		drain();

		test_id = 1;
		for (int i = 0; i < n_wakeup; i++) begin
			base = $random(seed);
			offset = $random(seed);
			data = $random(seed);
			tag_b = next_tag;
			tag_d = next_tag + 1'b1;
			next_tag = next_tag + 2'd2;
			case (i % 4)
				0: begin
					dispatch_store(base, 1'b1, offset, data, 1'b1, tag_b, tag_d);
				end
				1: begin
					dispatch_store(base, 1'b0, offset, data, 1'b1, tag_b, tag_d);
					next_cycle();
					broadcast(tag_b, base);
				end
				2: begin
					dispatch_store(base, 1'b1, offset, data, 1'b0, tag_b, tag_d);
					broadcast(tag_d, data);
				end
				default: begin
					// empty queue so the first broadcast meets the dispatch
					drain();
					cdb_valid = 1'b1;
					if (i % 8 == 3) begin
						cdb_tag = tag_d;
						cdb_value = data;
					end else begin
						cdb_tag = tag_b;
						cdb_value = base;
					end
					dispatch_store(base, 1'b0, offset, data, 1'b0, tag_b, tag_d);
					next_cycle();
					if (i % 8 == 3) begin
						broadcast(tag_b, base);
					end else begin
						broadcast(tag_d, data);
					end
				end
			endcase
		end
		drain();

		test_id = 2;
		ready_mode = ready_random;
		send_ready_stores(n_backpressure);
		drain();

		// fill the queue while the cache refuses
		test_id = 3;
		ready_mode = ready_low;
		send_ready_stores(sq_depth);
		disp_valid = 1'b1;
		repeat (4) begin
			if (disp_ready) begin
				$display("disp_ready is high with %0d stores outstanding", sq_depth);
				other_errors++;
			end
			next_cycle();
		end
		ready_mode = ready_high;
		send_ready_stores(n_full - sq_depth);
		drain();

		test_id = 4;
		ready_mode = ready_low;
		send_ready_stores(n_flush / 2);
		repeat (3) next_cycle();
		mispredict = 1'b1;
		next_cycle();
		mispredict = 1'b0;
		ready_mode = ready_high;
		repeat (6) begin
			next_cycle();
			if (store_valid || !disp_ready) begin
				$display("the queue still holds stores after the mispredict");
				other_errors++;
			end
		end
		send_ready_stores(n_flush - n_flush / 2);
		drain();
		repeat (5) next_cycle();

		total = error_count + other_errors + dut.u_sq_assert.failures;
		$display("checked %0d stores: %0d checker errors, %0d assertion failures, %0d other errors",
			check_count, error_count, dut.u_sq_assert.failures, other_errors);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
sq_config_pkg.sv
sq_types_pkg.sv
sq_alloc.sv
sq_entry_array.sv
sq_agu.sv
sq_commit.sv
store_queue.sv
sq_assert.sv
tb_clock_gen.sv
tb_checker.sv
tb_store_queue.sv
